//--- rtl/bch_pkg.sv
// BCH (15,5) decoder shared definitions.
// Code constants, the GF(2^4) element type and the field arithmetic
// used by the syndrome, Berlekamp-Massey and Chien stages.

`default_nettype none

package bch_pkg;

  localparam int m      = 4;   // field degree, bits per element.
  localparam int n      = 15;  // code length in bits.
  localparam int t      = 3;   // correctable errors.
  localparam int t2     = 6;   // number of syndromes.
  localparam int irrpol = 19;  // x^4 + x + 1.

  typedef logic [m-1:0] data_t;  // one field element.
  typedef logic [3:0]   cnt_t;   // bit position, 0..14.

  // polynomial product of a and b, then folded back by irrpol.
  function automatic data_t gf_mul(input data_t a, input data_t b);
    logic [2*m-2:0] p;
    p = '0;
    for (int i = 0; i < m; i++) begin
      if (b[i]) p ^= (2*m-1)'(a) << i;  // partial product.
    end
    for (int i = 2*m-2; i >= m; i--) begin
      if (p[i]) p ^= (2*m-1)'(irrpol) << (i - m);  // clear the top bit.
    end
    return p[m-1:0];
  endfunction

  // alpha^e, the exponent taken modulo n so negative powers work too.
  function automatic data_t gf_pow_alpha(input int e);
    int    r;
    data_t a;
    r = e % n;
    if (r < 0) r += n;  // the % result keeps the sign of e.
    a = data_t'(1);
    for (int i = 0; i < n; i++) begin
      if (i < r) a = gf_mul(a, data_t'(2));  // alpha is the element 2.
    end
    return a;
  endfunction

endpackage

`default_nettype wire

//--- rtl/bch_syndrome.sv
// BCH syndrome stage.
// Evaluates the received polynomial at alpha^1..alpha^6 by Horner's rule,
// one bit per strobe, highest degree first, and keeps the received word.

`timescale 1ns/1ps
`default_nettype none

module bch_syndrome
  import bch_pkg::*;
(
  input  logic         iclk,
  input  logic         rst_n,
  input  logic         bit_val,
  input  logic         bit_sop,
  input  logic         bit_in,
  output logic         syn_val,
  output data_t        syndrome [1:t2],
  output logic [n-1:0] word
);

  cnt_t         bit_cnt;         // bits taken so far in the current word.
  data_t        acc    [1:t2];   // running Horner sums.
  data_t        acc_nx [1:t2];
  logic [n-2:0] sreg;            // first 14 bits, the 15th joins on the fly.
  logic         last_bit;

  // the 15th bit of a word, a sop here would be a new word instead.
  assign last_bit = bit_val && !bit_sop && (bit_cnt == cnt_t'(n-1));

  // S_i <- S_i * alpha^i + r. a sop drops whatever the sum held before.
  always_comb begin
    for (int i = 1; i <= t2; i++) begin
      acc_nx[i] = (bit_sop ? data_t'(0) : gf_mul(acc[i], gf_pow_alpha(i))) ^ data_t'(bit_in);
    end
  end

  //################################################
  // control
  //################################################

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      bit_cnt <= '0;  // a half-received word is thrown away.
      syn_val <= 1'b0;
    end else begin
      syn_val <= last_bit;  // one pulse, the cycle after the 15th bit.
      if (bit_val && bit_sop) bit_cnt <= cnt_t'(1);
      else if (last_bit) bit_cnt <= '0;
      else if (bit_val && bit_cnt != '0) bit_cnt <= bit_cnt + cnt_t'(1);  // stray bits are ignored.
    end
  end

  // accumulators and the word hold data only.
  always_ff @(posedge iclk) begin
    if (bit_val) begin
      acc  <= acc_nx;
      sreg <= {sreg[n-3:0], bit_in};
    end
    if (last_bit) begin
      syndrome <= acc_nx;          // held until the next word completes.
      word     <= {sreg, bit_in};
    end
  end

  // a new word may only start once the previous one is complete.
  a_sop_at_word_start : assert property (@(posedge iclk) disable iff (!rst_n)
    (bit_val && bit_sop) |-> (bit_cnt == '0));

endmodule

`default_nettype wire

//--- rtl/bch_berlekamp.sv
// BCH Berlekamp-Massey stage.
// Simplified inversionless binary form: only odd syndrome steps are run,
// three iterations, one per clock, giving the error locator polynomial.
// The locator is kept to six coefficients inside so that a degree above
// t is seen, and such a locator leaves this stage as all zero.

`timescale 1ns/1ps
`default_nettype none

module bch_berlekamp
  import bch_pkg::*;
(
  input  logic         iclk,
  input  logic         rst_n,
  input  logic         syn_val,
  input  data_t        syndrome [1:t2],
  input  logic [n-1:0] word,
  output logic         loc_val,
  output data_t        loc_poly [0:t],
  output logic [n-1:0] loc_word
);

  logic              busy;                // an iteration is running.
  logic [1:0]        it;                  // iteration index r.
  data_t             syn_r     [1:t2];
  data_t             lambda    [0:t2-1];  // locator.
  data_t             lambda_nx [0:t2-1];
  data_t             b_poly    [0:t2-1];  // correction polynomial B.
  data_t             gamma;               // previous nonzero discrepancy.
  data_t             delta;               // current discrepancy.
  logic signed [3:0] k;                   // length balance.
  logic              reload;
  logic              ovf;                 // degree went past t.
  logic [n-1:0]      word_r;

  //################################################
  // discrepancy and locator update
  //################################################

  // delta = sum lambda_i * S_(2r+1-i). syndromes below S1 do not exist.
  always_comb begin
    delta = '0;
    for (int i = 0; i <= t; i++) begin
      if (2 * int'(it) + 1 - i >= 1) delta ^= gf_mul(lambda[i], syn_r[2 * int'(it) + 1 - i]);
    end
  end

  // lambda <- gamma * lambda + delta * x * B.
  always_comb begin
    lambda_nx[0] = gf_mul(gamma, lambda[0]);
    for (int j = 1; j < t2; j++) begin
      lambda_nx[j] = gf_mul(gamma, lambda[j]) ^ gf_mul(delta, b_poly[j-1]);
    end
  end

  assign reload = (delta != '0) && (k >= 0);  // the locator length grows.

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      it      <= '0;
      loc_val <= 1'b0;
    end else begin
      loc_val <= 1'b0;
      if (syn_val) begin
        busy <= 1'b1;  // this cycle only loads.
        it   <= '0;
      end else if (busy) begin
        it <= it + 2'd1;
        if (it == 2'(t-1)) begin
          busy    <= 1'b0;
          loc_val <= 1'b1;  // t+1 cycles after syn_val.
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (syn_val) begin
      syn_r  <= syndrome;
      word_r <= word;
      for (int j = 0; j < t2; j++) begin
        lambda[j] <= (j == 0) ? data_t'(1) : data_t'(0);  // both start at 1.
        b_poly[j] <= (j == 0) ? data_t'(1) : data_t'(0);
      end
      gamma <= data_t'(1);
      k     <= '0;
    end else if (busy) begin
      lambda    <= lambda_nx;
      b_poly[0] <= '0;
      if (reload) begin
        for (int j = 1; j < t2; j++) b_poly[j] <= lambda[j-1];  // B = x * old lambda.
        gamma <= delta;
        k     <= -k;
      end else begin
        b_poly[1] <= '0;
        for (int j = 2; j < t2; j++) b_poly[j] <= b_poly[j-2];  // B = x^2 * B.
        k <= k + 4'sd2;
      end
    end
  end

  //################################################
  // result
  //################################################

  always_comb begin
    ovf = 1'b0;
    for (int j = t + 1; j < t2; j++) ovf |= (lambda[j] != '0);
  end

  // a zero locator makes every position look like a root, so the Chien
  // stage sees a root count that can never match and flags the word.
  always_comb begin
    for (int j = 0; j <= t; j++) loc_poly[j] = ovf ? data_t'(0) : lambda[j];
  end

  assign loc_word = word_r;

  // the stage cannot stall, a word arriving mid-iteration is lost.
  a_no_syn_while_busy : assert property (@(posedge iclk) disable iff (!rst_n)
    syn_val |-> !busy);

endmodule

`default_nettype wire

//--- rtl/bch_chien.sv
// BCH Chien search stage.
// Evaluates the locator at alpha^-14 .. alpha^0, one position per cycle,
// flips the bits at the roots and streams the corrected word, highest
// degree first. Flags a failure when the roots do not match the degree.

`timescale 1ns/1ps
`default_nettype none

module bch_chien
  import bch_pkg::*;
(
  input  logic         iclk,
  input  logic         rst_n,
  input  logic         loc_val,
  input  data_t        loc_poly [0:t],
  input  logic [n-1:0] loc_word,
  output logic         dout_val,
  output logic         dout_sop,
  output logic         dout_eop,
  output logic         dout,
  output logic         decfail
);

  data_t        term [0:t];   // lambda_j * alpha^(-p*j) for position p.
  data_t        term_sum;
  logic         root;
  logic         active;
  cnt_t         pos_cnt;      // output bit index, 0 is degree 14.
  cnt_t         nroots;
  cnt_t         roots_total;
  cnt_t         deg;
  cnt_t         deg_in;
  logic [n-1:0] wsr;          // word, top bit is the current position.

  always_comb begin
    term_sum = '0;
    for (int j = 0; j <= t; j++) term_sum ^= term[j];
  end

  assign root        = (term_sum == '0);  // lambda(alpha^-p) == 0.
  assign roots_total = nroots + cnt_t'(root);

  // degree is the highest nonzero coefficient. it never exceeds t here,
  // a longer locator reaches this stage as all zero.
  always_comb begin
    deg_in = '0;
    for (int j = 1; j <= t; j++) begin
      if (loc_poly[j] != '0) deg_in = cnt_t'(j);
    end
  end

  //################################################
  // output
  //################################################

  assign dout_val = active;
  assign dout_sop = active && (pos_cnt == '0);
  assign dout_eop = active && (pos_cnt == cnt_t'(n-1));
  assign dout     = wsr[n-1] ^ root;  // correction.
  assign decfail  = dout_eop && (roots_total != deg);  // counts the last root too.

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      active  <= 1'b0;
      pos_cnt <= '0;
      nroots  <= '0;
    end else if (loc_val) begin
      active  <= 1'b1;  // a new word may follow straight on the eop cycle.
      pos_cnt <= '0;
      nroots  <= '0;
    end else if (active) begin
      pos_cnt <= pos_cnt + cnt_t'(1);
      nroots  <= roots_total;
      if (pos_cnt == cnt_t'(n-1)) active <= 1'b0;
    end
  end

  always_ff @(posedge iclk) begin
    if (loc_val) begin
      for (int j = 0; j <= t; j++) term[j] <= gf_mul(loc_poly[j], gf_pow_alpha(-(n-1) * j));
      wsr <= loc_word;
      deg <= deg_in;
    end else if (active) begin
      for (int j = 0; j <= t; j++) term[j] <= gf_mul(term[j], gf_pow_alpha(j));  // next p.
      wsr <= wsr << 1;
    end
  end

  // every word comes out as one unbroken burst of n bits.
  a_dout_burst : assert property (@(posedge iclk) disable iff (!rst_n)
    dout_sop |-> dout_val [*n] ##1 (!dout_val || dout_sop));

  // a locator may only arrive when the search is idle or on its last bit.
  a_loc_when_free : assert property (@(posedge iclk) disable iff (!rst_n)
    loc_val |-> (!active || dout_eop));

endmodule

`default_nettype wire

//--- rtl/bch_dec.sv
// BCH (15,5) serial decoder, top level.
// Syndrome, Berlekamp-Massey and Chien stages in a pipeline, up to three
// words in flight. Corrects up to three bit errors per word.

`timescale 1ns/1ps
`default_nettype none

module bch_dec
  import bch_pkg::*;
(
  input  logic iclk,
  input  logic rst_n,
  input  logic bit_val,
  input  logic bit_sop,
  input  logic bit_in,
  output logic dout_val,
  output logic dout_sop,
  output logic dout_eop,
  output logic dout,
  output logic decfail
);

  logic         syn_val;
  data_t        syndrome [1:t2];
  logic [n-1:0] word;
  logic         loc_val;
  data_t        loc_poly [0:t];
  logic [n-1:0] loc_word;

  bch_syndrome u_syndrome (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .bit_val  (bit_val),
    .bit_sop  (bit_sop),
    .bit_in   (bit_in),
    .syn_val  (syn_val),
    .syndrome (syndrome),
    .word     (word)
  );

  bch_berlekamp u_berlekamp (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .syn_val  (syn_val),
    .syndrome (syndrome),
    .word     (word),
    .loc_val  (loc_val),
    .loc_poly (loc_poly),
    .loc_word (loc_word)
  );

  bch_chien u_chien (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .loc_val  (loc_val),
    .loc_poly (loc_poly),
    .loc_word (loc_word),
    .dout_val (dout_val),
    .dout_sop (dout_sop),
    .dout_eop (dout_eop),
    .dout     (dout),
    .decfail  (decfail)
  );

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
// Testbench clock and reset source.
// A 4 ns clock, with reset held low for three rising edges.

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic iclk,
  output logic rst_n
);

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;  // 2 ns high, 2 ns low.
  end

  // released on a falling edge, like every other DUT input.
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge iclk);
    @(negedge iclk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/bch_dec_tb.sv
// BCH (15,5) decoder testbench.
// Directed tests send coded words bit by bit, with errors injected at
// random positions, and check the corrected words and the failure flag.
// Codewords come from a reference encoder that multiplies by g(x).

`timescale 1ns/1ps
`default_nettype none

module bch_dec_tb
  import bch_pkg::*;
();

  localparam logic [10:0] gen_poly        = 11'h537;  // x^10+x^8+x^5+x^4+x^2+x+1.
  localparam int          total_words     = 63;       // words over all the tests.
  localparam int          cycles_per_word = 40;

  logic         iclk;
  logic         rst_n;
  logic         bit_val;
  logic         bit_sop;
  logic         bit_in;
  logic         dout_val;
  logic         dout_sop;
  logic         dout_eop;
  logic         dout;
  logic         decfail;
  logic [31:0]  lcg_state;
  logic [n-1:0] tx_q [$];       // words waiting to go in.
  logic [n-1:0] exp_q [$];      // expected corrected words, in order.
  logic [n-1:0] rx_word_q [$];  // words seen on dout.
  logic         rx_fail_q [$];  // decfail taken on each last bit.
  logic [n-1:0] rx_shift;
  int           rx_bits      = 0;  // bits of the current output word so far.
  int           val_count    = 0;
  int           fail_count   = 0;
  int           errors       = 0;
  int           tests_run    = 0;
  int           tests_failed = 0;

  tb_clkgen u_clkgen (.iclk(iclk), .rst_n(rst_n));

  bch_dec u_dut (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .bit_val  (bit_val),
    .bit_sop  (bit_sop),
    .bit_in   (bit_in),
    .dout_val (dout_val),
    .dout_sop (dout_sop),
    .dout_eop (dout_eop),
    .dout     (dout),
    .decfail  (decfail)
  );

  //################################################
  // stimulus helpers
  //################################################

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes constants.
    return lcg_state;
  endfunction

  function automatic int rand_pos();
    logic [31:0] r;
    r = lcg_next();
    return int'(r[23:16]) % n;  // the upper bits are the better ones.
  endfunction

  // a codeword is the message polynomial times g(x).
  function automatic logic [n-1:0] encode(input logic [4:0] msg);
    logic [n-1:0] cw;
    cw = '0;
    for (int i = 0; i < 5; i++) begin
      if (msg[i]) cw ^= {4'b0, gen_poly} << i;
    end
    return cw;
  endfunction

  function automatic logic [n-1:0] random_codeword();
    logic [31:0] r;
    r = lcg_next();
    return encode(r[20:16]);
  endfunction

  // long division by g(x), a zero remainder means a codeword.
  function automatic logic is_codeword(input logic [n-1:0] w);
    logic [n-1:0] rem;
    rem = w;
    for (int i = n - 1; i >= 10; i--) begin
      if (rem[i]) rem ^= {4'b0, gen_poly} << (i - 10);
    end
    return rem == '0;
  endfunction

  // cnt distinct error positions.
  function automatic logic [n-1:0] error_mask(input int cnt);
    logic [n-1:0] mask;
    int           pos;
    mask = '0;
    while ($countones(mask) < cnt) begin
      pos = rand_pos();
      mask[pos] = 1'b1;
    end
    return mask;
  endfunction

  // sends every queued word, highest degree first, then gap idle cycles.
  task automatic send_queued(input int gap);
    logic [n-1:0] w;
    while (tx_q.size() > 0) begin
      w = tx_q.pop_front();
      for (int i = n - 1; i >= 0; i--) begin
        @(negedge iclk);
        bit_val = 1'b1;
        bit_sop = (i == n - 1);
        bit_in  = w[i];
      end
      for (int g = 0; g < gap; g++) begin
        @(negedge iclk);
        bit_val = 1'b0;
        bit_sop = 1'b0;
      end
    end
    @(negedge iclk);
    bit_val = 1'b0;
    bit_sop = 1'b0;
  endtask

  //################################################
  // output monitor and checks
  //################################################

  // outputs change on the rising edge and are taken half a cycle later.
  // each word is n bits long, with sop on its first and eop on its last.
  always @(negedge iclk) begin
    if (dout_val === 1'b1) begin
      val_count++;
      check_flag("dout_sop", rx_bits == 0, dout_sop);
      check_flag("dout_eop", rx_bits == n - 1, dout_eop);
      rx_shift = {rx_shift[n-2:0], dout};  // first bit ends up as bit 14.
      if (rx_bits == n - 1) begin
        rx_word_q.push_back(rx_shift);
        rx_fail_q.push_back(decfail);
        rx_bits = 0;
      end else begin
        rx_bits++;
      end
    end
    if (decfail === 1'b1) fail_count++;
  end

  task automatic check_word(input string name, input logic [n-1:0] exp,
                            input logic [n-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  // waits for count words on dout, each allowed a fixed share of time.
  task automatic wait_outputs(input string test_name, input int count);
    int cycles;
    cycles = 0;
    while (rx_word_q.size() < count && cycles < count * cycles_per_word) begin
      @(negedge iclk);
      cycles++;
    end
    if (rx_word_q.size() < count) begin
      $display("%s: only %0d of %0d words came out of the decoder", test_name,
               rx_word_q.size(), count);
      errors++;
    end
  endtask

  // every expected word must come back exactly, with no failure flagged.
  task automatic check_results(input string test_name);
    logic [n-1:0] got;
    logic         fail;
    int           count;
    count = exp_q.size();
    wait_outputs(test_name, count);
    for (int i = 0; i < count && rx_word_q.size() > 0; i++) begin
      got  = rx_word_q.pop_front();
      fail = rx_fail_q.pop_front();
      check_word("dout", exp_q.pop_front(), got);
      check_flag("decfail", 1'b0, fail);
    end
    exp_q.delete();
  endtask

  task automatic finish_test(input string test_name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_before);
    end
  endtask

  //################################################
  // tests
  //################################################

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    repeat (2 * n + 10) @(negedge iclk);  // longer than a full decode.
    if (val_count != 0) begin
      $display("reset_state: dout_val rose although no word was sent");
      errors++;
    end
    if (fail_count != 0) begin
      $display("reset_state: decfail rose although no word was sent");
      errors++;
    end
    finish_test("reset_state", err0);
  endtask

  task automatic test_clean_words();
    logic [n-1:0] cw;
    int           err0;
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      cw = random_codeword();
      exp_q.push_back(cw);
      tx_q.push_back(cw);
    end
    send_queued(4);
    check_results("clean_words");
    finish_test("clean_words", err0);
  endtask

  task automatic test_single_errors();
    logic [n-1:0] cw;
    int           err0;
    err0 = errors;
    for (int p = 0; p < n; p++) begin
      cw = random_codeword();
      exp_q.push_back(cw);
      tx_q.push_back(cw ^ (15'(1) << p));  // every position once.
    end
    send_queued(4);
    check_results("single_errors");
    finish_test("single_errors", err0);
  endtask

  task automatic test_multi_errors();
    logic [n-1:0] cw;
    logic [31:0]  r;
    int           err0;
    err0 = errors;
    for (int i = 0; i < 20; i++) begin
      cw = random_codeword();
      r  = lcg_next();
      exp_q.push_back(cw);
      tx_q.push_back(cw ^ error_mask(2 + int'(r[16])));  // two or three errors.
    end
    send_queued(4);
    check_results("multi_errors");
    finish_test("multi_errors", err0);
  endtask

  // no idle cycles, so three words are inside the pipeline at once.
  task automatic test_back_to_back();
    logic [n-1:0] cw;
    logic [31:0]  r;
    int           err0;
    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      cw = random_codeword();
      r  = lcg_next();
      exp_q.push_back(cw);
      tx_q.push_back(cw ^ error_mask(int'(r[17:16])));
    end
    send_queued(0);
    check_results("back_to_back");
    finish_test("back_to_back", err0);
  endtask

  // beyond t the decoder must flag, or land on a codeword within t bits.
  task automatic test_four_errors();
    logic [n-1:0] rcv_q [$];
    logic [n-1:0] rcv;
    logic [n-1:0] got;
    logic         fail;
    int           err0;
    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      rcv = random_codeword() ^ error_mask(4);
      rcv_q.push_back(rcv);
      tx_q.push_back(rcv);
    end
    send_queued(4);
    wait_outputs("four_errors", 10);
    for (int i = 0; i < 10 && rx_word_q.size() > 0; i++) begin
      got  = rx_word_q.pop_front();
      fail = rx_fail_q.pop_front();
      rcv  = rcv_q.pop_front();
      if (fail !== 1'b1 && (!is_codeword(got) || $countones(got ^ rcv) > t)) begin
        $display("[ERROR] dout: word %0d is 0x%h, not flagged and not a codeword near 0x%h",
                 i, got, rcv);
        errors++;
      end
    end
    finish_test("four_errors", err0);
  endtask

  //################################################
  // main sequence and watchdog
  //################################################

  initial begin
    bit_val   = 1'b0;
    bit_sop   = 1'b0;
    bit_in    = 1'b0;
    lcg_state = 32'h1bc9;
    wait (rst_n === 1'b1);
    @(negedge iclk);
    test_reset_state();
    test_clean_words();
    test_single_errors();
    test_multi_errors();
    test_back_to_back();
    test_four_errors();
    $display("tests run %0d, passed %0d, failed %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (total_words * cycles_per_word + 200) @(posedge iclk);
    $display("timeout: the tests did not finish within %0d cycles",
             total_words * cycles_per_word + 200);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
rtl/bch_pkg.sv
rtl/bch_syndrome.sv
rtl/bch_berlekamp.sv
rtl/bch_chien.sv
rtl/bch_dec.sv
verification/tb_clkgen.sv
verification/bch_dec_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = bch_dec_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
